// ==== rtl/frontend_pkg.sv ====
// widths, table sizes and entry types shared by the fetch frontend blocks
package frontend_pkg;

  localparam int ADDR_W = 32;
  localparam int BLK_OFS = 4;
  localparam int GHR_W = 6;
  localparam int PIDX_W = 6;
  localparam int TB_IDX_W = 6;
  // ip bits left over above the target buffer index
  localparam int TAG_W = ADDR_W - BLK_OFS - TB_IDX_W;
  localparam int N_SLOT = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [GHR_W-1:0] ghr_t;

  // one direction bit per branch slot
  typedef logic [N_SLOT-1:0] pred_t;

  typedef struct packed {
    logic valid;
    logic [TAG_W-1:0] tag;
    addr_t target;
  } tb_entry_t;

endpackage

// ==== rtl/lookup_if.sv ====
// lookup path between fetch control and the direction and target predictors
`timescale 1ns/100ps

interface lookup_if;

  frontend_pkg::addr_t ip;
  frontend_pkg::ghr_t ghr;
  // predictor answers
  frontend_pkg::pred_t dir_pred;
  frontend_pkg::addr_t [frontend_pkg::N_SLOT-1:0] tgt_addr;
  logic [frontend_pkg::N_SLOT-1:0] hit;

  modport ctrl (output ip, output ghr, input dir_pred, input tgt_addr, input hit);

  modport dir (input ip, input ghr, output dir_pred);

  modport tgt (input ip, output tgt_addr, output hit);

endinterface

// ==== rtl/retire_if.sv ====
// retired branch data fanned out from fetch control to the predictors for training
`timescale 1ns/100ps

interface retire_if;

  logic ret_valid;
  logic ret_slot;
  logic ret_mispredict;
  frontend_pkg::addr_t ret_src_ip;
  frontend_pkg::addr_t ret_target;
  frontend_pkg::ghr_t ret_ghr;

  modport src (
    output ret_valid, output ret_slot, output ret_mispredict,
    output ret_src_ip, output ret_target, output ret_ghr
  );

  modport sink (
    input ret_valid, input ret_slot, input ret_mispredict,
    input ret_src_ip, input ret_target, input ret_ghr
  );

endinterface

// ==== rtl/tbl_ram.sv ====
// small indexed table, async read and clocked write, used for predictor and target storage
`timescale 1ns/100ps

module tbl_ram #(
  parameter type payload_t = logic,
  parameter int IDX_W = 6
) (
  input  logic clk,
  input  logic rst,
  input  logic [IDX_W-1:0] rd_idx,
  output payload_t rd_data,
  input  logic wr_en,
  input  logic [IDX_W-1:0] wr_idx,
  input  payload_t wr_data
);

  localparam int DEPTH = 1 << IDX_W;

  payload_t mem [DEPTH];

  assign rd_data = mem[rd_idx];

  // cleared table reads as not taken and invalid
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

endmodule

// ==== rtl/direction_predictor.sv ====
// taken/not-taken prediction from three hashed tables, toggled on retire mispredicts
`timescale 1ns/100ps

module direction_predictor (
  input logic clk,
  input logic rst,
  lookup_if.dir lkp,
  retire_if.sink ret
);

  localparam int N_TBL = 3;

  // upper bits from ip just above the block offset, low bits from history
  function automatic logic [frontend_pkg::PIDX_W-1:0] hash_idx(
    input frontend_pkg::addr_t ip,
    input frontend_pkg::ghr_t ghr,
    input int ip_bits
  );
    logic [frontend_pkg::PIDX_W-1:0] idx;
    int ghr_bits;
    ghr_bits = frontend_pkg::PIDX_W - ip_bits;
    for (int i = 0; i < frontend_pkg::PIDX_W; i++) begin
      if (i < ghr_bits) begin
        idx[i] = ghr[i];
      end else begin
        idx[i] = ip[frontend_pkg::BLK_OFS + i - ghr_bits];
      end
    end
    return idx;
  endfunction

  logic train;
  frontend_pkg::pred_t slot_mask;
  frontend_pkg::pred_t entry [N_TBL];

  assign train = ret.ret_valid && ret.ret_mispredict;
  assign slot_mask = frontend_pkg::pred_t'(1) << ret.ret_slot;

  for (genvar t = 0; t < N_TBL; t++) begin : g_tbl
    localparam int IP_BITS = (t == 0) ? 4 : (t == 1) ? 2 : 0;

    logic [frontend_pkg::PIDX_W-1:0] lkp_idx;
    logic [frontend_pkg::PIDX_W-1:0] trn_idx;
    logic [frontend_pkg::PIDX_W-1:0] rd_idx;

    assign lkp_idx = hash_idx(lkp.ip, lkp.ghr, IP_BITS);
    assign trn_idx = hash_idx(ret.ret_src_ip, ret.ret_ghr, IP_BITS);
    // training takes the read port while a mispredict redirects
    assign rd_idx = train ? trn_idx : lkp_idx;

    tbl_ram #(
      .payload_t(frontend_pkg::pred_t),
      .IDX_W(frontend_pkg::PIDX_W)
    ) u_tbl (
      .clk(clk),
      .rst(rst),
      .rd_idx(rd_idx),
      .rd_data(entry[t]),
      .wr_en(train),
      .wr_idx(trn_idx),
      .wr_data(entry[t] ^ slot_mask)
    );
  end

  // flipping all three tables flips the combined bit
  assign lkp.dir_pred = entry[0] ^ entry[1] ^ entry[2];

endmodule

// ==== rtl/target_buffer.sv ====
// per-slot branch target storage with tag check, written on every retired branch
`timescale 1ns/100ps

module target_buffer (
  input logic clk,
  input logic rst,
  lookup_if.tgt lkp,
  retire_if.sink ret
);

  localparam int IDX_LO = frontend_pkg::BLK_OFS;
  localparam int TAG_LO = frontend_pkg::BLK_OFS + frontend_pkg::TB_IDX_W;

  logic [frontend_pkg::TB_IDX_W-1:0] lkp_idx;
  logic [frontend_pkg::TAG_W-1:0] lkp_tag;
  logic [frontend_pkg::TB_IDX_W-1:0] ret_idx;
  frontend_pkg::tb_entry_t new_ent;

  assign lkp_idx = lkp.ip[IDX_LO +: frontend_pkg::TB_IDX_W];
  assign lkp_tag = lkp.ip[TAG_LO +: frontend_pkg::TAG_W];
  assign ret_idx = ret.ret_src_ip[IDX_LO +: frontend_pkg::TB_IDX_W];

  always_comb begin
    new_ent.valid = 1'b1;
    new_ent.tag = ret.ret_src_ip[TAG_LO +: frontend_pkg::TAG_W];
    new_ent.target = ret.ret_target;
  end

  for (genvar s = 0; s < frontend_pkg::N_SLOT; s++) begin : g_slot
    frontend_pkg::tb_entry_t rd_ent;
    logic wr_en;

    // only the retiring slot gets the new target
    assign wr_en = ret.ret_valid && (ret.ret_slot == 1'(s));

    tbl_ram #(
      .payload_t(frontend_pkg::tb_entry_t),
      .IDX_W(frontend_pkg::TB_IDX_W)
    ) u_slot (
      .clk(clk),
      .rst(rst),
      .rd_idx(lkp_idx),
      .rd_data(rd_ent),
      .wr_en(wr_en),
      .wr_idx(ret_idx),
      .wr_data(new_ent)
    );

    assign lkp.tgt_addr[s] = rd_ent.target;
    // tag mismatch counts as not taken
    assign lkp.hit[s] = rd_ent.valid && (rd_ent.tag == lkp_tag);
  end

endmodule

// ==== rtl/fetch_ctrl.sv ====
// fetch IP and history state, next-block choice per ack, and the read-only Wishbone master
`timescale 1ns/100ps

module fetch_ctrl #(
  parameter frontend_pkg::addr_t RESET_IP = 32'h0000_1000
) (
  input  logic clk,
  input  logic rst,
  input  logic wb_ack,
  output logic wb_cyc,
  output logic wb_stb,
  output frontend_pkg::addr_t wb_adr,
  input  logic ret_valid,
  input  logic ret_slot,
  input  logic ret_mispredict,
  input  frontend_pkg::addr_t ret_src_ip,
  input  frontend_pkg::addr_t ret_target,
  input  frontend_pkg::ghr_t ret_ghr,
  lookup_if.ctrl lkp,
  retire_if.src ret
);

  localparam int BLK_BYTES = 1 << frontend_pkg::BLK_OFS;

  frontend_pkg::addr_t ip_q;
  frontend_pkg::ghr_t ghr_q;
  logic cyc_q;
  logic pend_q;
  frontend_pkg::addr_t pend_tgt_q;
  frontend_pkg::ghr_t pend_ghr_q;

  logic mis_now;
  logic fetch_done;
  frontend_pkg::addr_t nxt_ip;
  frontend_pkg::ghr_t nxt_ghr;

  assign ret.ret_valid = ret_valid;
  assign ret.ret_slot = ret_slot;
  assign ret.ret_mispredict = ret_mispredict;
  assign ret.ret_src_ip = ret_src_ip;
  assign ret.ret_target = ret_target;
  assign ret.ret_ghr = ret_ghr;

  assign lkp.ip = ip_q;
  assign lkp.ghr = ghr_q;

  // stb stays high after reset so a slow ack is the only back-pressure
  assign wb_cyc = cyc_q;
  assign wb_stb = cyc_q;
  assign wb_adr = ip_q;

  assign mis_now = ret_valid && ret_mispredict;
  assign fetch_done = cyc_q && wb_ack;

  always_comb begin
    if (mis_now) begin
      nxt_ip = ret_target;
      nxt_ghr = ret_ghr;
    end else if (pend_q) begin
      nxt_ip = pend_tgt_q;
      nxt_ghr = pend_ghr_q;
    end else if (lkp.dir_pred[0] && lkp.hit[0]) begin
      nxt_ip = lkp.tgt_addr[0];
      nxt_ghr = {ghr_q[frontend_pkg::GHR_W-2:0], 1'b1};
    end else if (lkp.dir_pred[1] && lkp.hit[1]) begin
      nxt_ip = lkp.tgt_addr[1];
      nxt_ghr = {ghr_q[frontend_pkg::GHR_W-2:0], 1'b1};
    end else begin
      nxt_ip = ip_q + frontend_pkg::addr_t'(BLK_BYTES);
      nxt_ghr = {ghr_q[frontend_pkg::GHR_W-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q <= RESET_IP;
      ghr_q <= '0;
      cyc_q <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      cyc_q <= 1'b1;
      if (fetch_done) begin
        ip_q <= nxt_ip;
        ghr_q <= nxt_ghr;
        pend_q <= 1'b0;
      end else if (mis_now) begin
        pend_q <= 1'b1;
      end
    end
  end

  // redirect held until the outstanding fetch is acked
  always_ff @(posedge clk) begin
    if (mis_now && !fetch_done) begin
      pend_tgt_q <= ret_target;
      pend_ghr_q <= ret_ghr;
    end
  end

endmodule

// ==== rtl/bp_frontend.sv ====
// fetch-address frontend top, wires fetch control to the direction and target predictors
`timescale 1ns/100ps

module bp_frontend #(
  parameter frontend_pkg::addr_t RESET_IP = 32'h0000_1000
) (
  input  logic clk,
  input  logic rst,
  input  logic wb_ack,
  output logic wb_cyc,
  output logic wb_stb,
  output frontend_pkg::addr_t wb_adr,
  input  logic ret_valid,
  input  logic ret_slot,
  input  logic ret_mispredict,
  input  frontend_pkg::addr_t ret_src_ip,
  input  frontend_pkg::addr_t ret_target,
  input  frontend_pkg::ghr_t ret_ghr
);

  lookup_if lkp ();
  retire_if ret ();

  fetch_ctrl #(
    .RESET_IP(RESET_IP)
  ) u_fetch_ctrl (
    .clk(clk),
    .rst(rst),
    .wb_ack(wb_ack),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_adr(wb_adr),
    .ret_valid(ret_valid),
    .ret_slot(ret_slot),
    .ret_mispredict(ret_mispredict),
    .ret_src_ip(ret_src_ip),
    .ret_target(ret_target),
    .ret_ghr(ret_ghr),
    .lkp(lkp.ctrl),
    .ret(ret.src)
  );

  direction_predictor u_dir (
    .clk(clk),
    .rst(rst),
    .lkp(lkp.dir),
    .ret(ret.sink)
  );

  target_buffer u_tgt (
    .clk(clk),
    .rst(rst),
    .lkp(lkp.tgt),
    .ret(ret.sink)
  );

endmodule

// ==== verif/bp_checker.sv ====
// reference model of the fetch frontend, checks each acked address and the Wishbone hold rules
`timescale 1ns/100ps

module bp_checker #(
  parameter frontend_pkg::addr_t RESET_IP = 32'h0000_1000
) (
  input logic clk,
  input logic rst,
  input logic wb_ack,
  input logic wb_cyc,
  input logic wb_stb,
  input frontend_pkg::addr_t wb_adr,
  input logic ret_valid,
  input logic ret_slot,
  input logic ret_mispredict,
  input frontend_pkg::addr_t ret_src_ip,
  input frontend_pkg::addr_t ret_target,
  input frontend_pkg::ghr_t ret_ghr,
  output int ack_count,
  output int value_errs,
  output int proto_errs
);

  frontend_pkg::pred_t dir_tbl [3][64];
  frontend_pkg::tb_entry_t tgt_tbl [frontend_pkg::N_SLOT][64];
  frontend_pkg::addr_t m_ip;
  frontend_pkg::ghr_t m_ghr;
  logic m_pend;
  frontend_pkg::addr_t m_pend_tgt;
  frontend_pkg::ghr_t m_pend_ghr;
  frontend_pkg::addr_t held_adr;
  string exp_kind;
  int n_acks = 0;
  int n_val = 0;
  int n_proto = 0;
  logic rst_seen = 1'b0;
  logic started = 1'b0;
  logic hold = 1'b0;

  assign ack_count = n_acks;
  assign value_errs = n_val;
  assign proto_errs = n_proto;

  // table a takes 4 ip bits, table b 2, table c history only
  function automatic logic [5:0] dir_index(input int tbl, input frontend_pkg::addr_t ip,
                                           input frontend_pkg::ghr_t ghr);
    case (tbl)
      0: return {ip[7:4], ghr[1:0]};
      1: return {ip[5:4], ghr[3:0]};
      default: return ghr;
    endcase
  endfunction

  function automatic frontend_pkg::addr_t next_addr(
    input logic mis,
    input frontend_pkg::addr_t tgt,
    input frontend_pkg::ghr_t rghr,
    output frontend_pkg::ghr_t nghr,
    output string kind
  );
    frontend_pkg::pred_t dir;
    frontend_pkg::tb_entry_t ent;
    frontend_pkg::addr_t nip;
    dir = '0;
    for (int t = 0; t < 3; t++) begin
      dir = dir ^ dir_tbl[t][dir_index(t, m_ip, m_ghr)];
    end
    // lowest priority first so later rules override
    nip = m_ip + 32'd16;
    nghr = {m_ghr[4:0], 1'b0};
    kind = "sequential";
    for (int s = frontend_pkg::N_SLOT - 1; s >= 0; s--) begin
      ent = tgt_tbl[s][m_ip[9:4]];
      if (dir[s] && ent.valid && ent.tag == m_ip[31:10]) begin
        nip = ent.target;
        nghr = {m_ghr[4:0], 1'b1};
        kind = $sformatf("taken_slot%0d", s);
      end
    end
    if (m_pend) begin
      nip = m_pend_tgt;
      nghr = m_pend_ghr;
      kind = "redirect_pending";
    end
    if (mis) begin
      nip = tgt;
      nghr = rghr;
      kind = "redirect_now";
    end
    return nip;
  endfunction

  always @(posedge clk) begin
    frontend_pkg::ghr_t nghr;
    string kind;
    logic [5:0] k;
    if (rst) begin
      for (int i = 0; i < 64; i++) begin
        for (int t = 0; t < 3; t++) begin
          dir_tbl[t][i] = '0;
        end
        for (int s = 0; s < frontend_pkg::N_SLOT; s++) begin
          tgt_tbl[s][i] = '0;
        end
      end
      m_ip = RESET_IP;
      m_ghr = '0;
      m_pend = 1'b0;
      exp_kind = "reset_ip";
      if (rst_seen && (wb_cyc !== 1'b0 || wb_stb !== 1'b0)) begin
        $display("error: wb_cyc or wb_stb high during reset");
        n_proto++;
      end
      rst_seen = 1'b1;
      started = 1'b0;
      hold = 1'b0;
    end else begin
      if (started && (wb_cyc !== 1'b1 || wb_stb !== 1'b1)) begin
        $display("error: wb_cyc or wb_stb not held high after reset");
        n_proto++;
      end
      if (hold && wb_adr !== held_adr) begin
        $display("error: wb_adr moved from %08h to %08h before ack", held_adr, wb_adr);
        n_proto++;
      end
      if (wb_cyc && wb_ack) begin
        n_acks++;
        if (wb_adr !== m_ip) begin
          $display("FAIL %s: expected %08h, actual %08h", exp_kind, m_ip, wb_adr);
          n_val++;
        end
        m_ip = next_addr(ret_valid && ret_mispredict, ret_target, ret_ghr, nghr, kind);
        m_ghr = nghr;
        exp_kind = kind;
        m_pend = 1'b0;
      end else if (ret_valid && ret_mispredict) begin
        m_pend = 1'b1;
        m_pend_tgt = ret_target;
        m_pend_ghr = ret_ghr;
      end
      // training lands after this cycle's lookup
      if (ret_valid) begin
        tgt_tbl[ret_slot][ret_src_ip[9:4]].valid = 1'b1;
        tgt_tbl[ret_slot][ret_src_ip[9:4]].tag = ret_src_ip[31:10];
        tgt_tbl[ret_slot][ret_src_ip[9:4]].target = ret_target;
        if (ret_mispredict) begin
          for (int t = 0; t < 3; t++) begin
            k = dir_index(t, ret_src_ip, ret_ghr);
            dir_tbl[t][k] = dir_tbl[t][k] ^ (frontend_pkg::pred_t'(1) << ret_slot);
          end
        end
      end
      hold = wb_cyc && wb_stb && !wb_ack;
      held_adr = wb_adr;
      started = 1'b1;
    end
  end

endmodule

// ==== verif/tb_top.sv ====
// simulation top with clock, reset, Wishbone responder with random ack delay and retire traffic
`timescale 1ns/100ps

module tb_top;

  localparam frontend_pkg::addr_t RESET_IP = 32'h0000_1200;
  localparam int N_ACKS = 2000;
  localparam int QUIET_CYCLES = 150;
  localparam int CYCLE_LIMIT = N_ACKS * 4 + 200;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic wb_ack = 1'b0;
  logic wb_cyc;
  logic wb_stb;
  frontend_pkg::addr_t wb_adr;
  logic ret_valid = 1'b0;
  logic ret_slot = 1'b0;
  logic ret_mispredict = 1'b0;
  frontend_pkg::addr_t ret_src_ip = '0;
  frontend_pkg::addr_t ret_target = '0;
  frontend_pkg::ghr_t ret_ghr = '0;
  int ack_count;
  int value_errs;
  int proto_errs;
  int cycles = 0;
  int unsigned ack_wait = 0;
  int unsigned dly;
  logic timed_out;

  // pairs share a target buffer index with different tags
  function automatic frontend_pkg::addr_t pick_block(input int unsigned sel);
    case (sel % 8)
      0: return 32'h0000_1000;
      1: return 32'h0000_1400;
      2: return 32'h0000_1010;
      3: return 32'h0000_1410;
      4: return 32'h0000_1040;
      5: return 32'h0000_2040;
      6: return 32'h0000_1200;
      default: return 32'h0000_3200;
    endcase
  endfunction

  bp_frontend #(.RESET_IP(RESET_IP)) dut0 (
    .clk(clk), .rst(rst), .wb_ack(wb_ack), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_adr(wb_adr), .ret_valid(ret_valid), .ret_slot(ret_slot),
    .ret_mispredict(ret_mispredict), .ret_src_ip(ret_src_ip),
    .ret_target(ret_target), .ret_ghr(ret_ghr)
  );

  bp_checker #(.RESET_IP(RESET_IP)) chk0 (
    .clk(clk), .rst(rst), .wb_ack(wb_ack), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_adr(wb_adr), .ret_valid(ret_valid), .ret_slot(ret_slot),
    .ret_mispredict(ret_mispredict), .ret_src_ip(ret_src_ip),
    .ret_target(ret_target), .ret_ghr(ret_ghr),
    .ack_count(ack_count), .value_errs(value_errs), .proto_errs(proto_errs)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // ack responder and retire traffic share one random stream
  always @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      ack_wait <= 0;
    end else if (wb_cyc && wb_stb) begin
      if (wb_ack) begin
        dly = $urandom % 4;
        wb_ack <= (dly == 0);
        ack_wait <= (dly == 0) ? 0 : dly - 1;
      end else if (ack_wait == 0) begin
        wb_ack <= 1'b1;
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
    if (rst || cycles < QUIET_CYCLES) begin
      ret_valid <= 1'b0;
      ret_mispredict <= 1'b0;
    end else begin
      ret_valid <= ($urandom % 4) == 0;
      ret_mispredict <= ($urandom % 2) == 0;
      ret_slot <= 1'($urandom % 2);
      ret_src_ip <= pick_block($urandom);
      ret_target <= pick_block($urandom);
      ret_ghr <= frontend_pkg::ghr_t'($urandom);
    end
  end

  initial begin
    void'($urandom(32'h9e53f3f3));
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    while (ack_count < N_ACKS && cycles < CYCLE_LIMIT) begin
      @(negedge clk);
    end
    timed_out = (ack_count < N_ACKS);
    if (timed_out) begin
      $display("error: timeout, only %0d of %0d fetches acked in %0d cycles",
               ack_count, N_ACKS, cycles);
    end
    $display("errors: value=%0d protocol=%0d timeout=%0d acks=%0d",
             value_errs, proto_errs, timed_out, ack_count);
    if (value_errs == 0 && proto_errs == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rtl/frontend_pkg.sv
rtl/lookup_if.sv
rtl/retire_if.sv
rtl/tbl_ram.sv
rtl/direction_predictor.sv
rtl/target_buffer.sv
rtl/fetch_ctrl.sv
rtl/bp_frontend.sv
verif/bp_checker.sv
verif/tb_top.sv

// ==== Makefile ====
SIM := obj_dir/sim_tb

$(SIM): files.f $(wildcard rtl/*.sv verif/*.sv)
	verilator --binary --timing -j 0 --top-module tb_top -f files.f --Mdir obj_dir -o sim_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	@! grep -q "Checks failed" sim.log
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
